//--- vlog.f
src/npu_pkg.sv
src/npu_circ_buf.sv
src/npu_proc_eng.sv
src/npu_accum_fifo.sv
src/npu_compute_unit.sv
dv/npu_compute_checker.sv
dv/npu_compute_unit_tb.sv

//--- Bender.yml
package:
  name: npu_compute_unit

sources:
  - files:
      - src/npu_pkg.sv
      - src/npu_circ_buf.sv
      - src/npu_proc_eng.sv
      - src/npu_accum_fifo.sv
      - src/npu_compute_unit.sv
  - target: test
    files:
      - dv/npu_compute_checker.sv
      - dv/npu_compute_unit_tb.sv

//--- dv/npu_compute_unit_tb.sv
module npu_compute_unit_tb;

  localparam int n_pe = 8;
  localparam int wbuf_depth = 8;  // small buffers so the replay wraps often
  localparam int obuf_depth = 4;
  localparam int fifo_depth = 4;

  localparam int ph_sweep = 0;  // compute off, out_sel still sweeps
  localparam int ph_config = 1;  // arg weights per PE, then one offset
  localparam int ph_load = 2;  // arg is one PE index, or n_pe for all of them
  localparam int ph_compute = 3;
  localparam int ph_fifo_wr = 4;
  localparam int ph_fifo_rd = 5;  // one pop clock, then arg-1 plain compute clocks
  localparam int n_phases = 14;
  localparam int margin = 20;  // slack in cycles on top of the table length

  int phase_code [n_phases] = '{ph_sweep, ph_config, ph_load, ph_compute, ph_fifo_wr,
                                ph_load, ph_compute, ph_fifo_wr, ph_fifo_rd, ph_fifo_rd,
                                ph_config, ph_load, ph_compute, ph_sweep};
  int phase_arg [n_phases] = '{8, 3, n_pe, 12, 1, 2, 8, 1, 10, 10, 1, 5, 10, 8};

  logic CLK;
  logic reset;
  logic state_compute;
  npu_pkg::data_t config_data;
  logic [n_pe-1:0] wbuf_wren;
  logic offset_buf_wren;
  logic [npu_pkg::pe_idx_w-1:0] pe_select_in;
  logic pe_write_en;
  npu_pkg::data_t input_data;
  logic acc_fifo_write_en;
  logic acc_fifo_read_en;
  logic [npu_pkg::pe_idx_w-1:0] out_sel;
  npu_pkg::acc_t pe_dout;

  logic [31:0] lfsr_state;
  int cycle_count = 0;
  int cycle_limit = 0;

  npu_compute_unit #(
    .n_pe(n_pe),
    .wbuf_depth(wbuf_depth),
    .obuf_depth(obuf_depth),
    .fifo_depth(fifo_depth)
  ) u_npu_compute_unit (.*);

  npu_compute_checker #(
    .n_pe(n_pe),
    .wbuf_depth(wbuf_depth),
    .obuf_depth(obuf_depth)
  ) u_checker (.*);

  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic npu_pkg::data_t random_word();
    npu_pkg::data_t word;
    word = '0;
    for (int b = 0; b < npu_pkg::data_w; b++) begin
      lfsr_state = lfsr_next(lfsr_state);  // one step for every bit taken
      word = {word[npu_pkg::data_w-2:0], lfsr_state[0]};
    end
    return word;
  endfunction

  function automatic int phase_cycles(input int code, input int arg);
    case (code)
      ph_config: return arg * n_pe + 1;
      ph_load: return (arg < n_pe) ? 1 : n_pe;
      ph_fifo_wr: return 1;
      default: return arg;
    endcase
  endfunction

  task next_cycle();
    @(posedge CLK);
    state_compute <= 1'b0;  // every strobe drops unless the phase raises it again
    wbuf_wren <= '0;
    offset_buf_wren <= 1'b0;
    pe_write_en <= 1'b0;
    acc_fifo_write_en <= 1'b0;
    acc_fifo_read_en <= 1'b0;
    out_sel <= out_sel + 1'b1;  // a continuous sweep over all PEs
  endtask

  task load_pe(input int k);
    next_cycle();
    pe_write_en <= 1'b1;
    pe_select_in <= npu_pkg::pe_idx_w'(k);
    input_data <= random_word();
  endtask

  task run_phase(input int code, input int arg);
    case (code)
      ph_config: begin
        for (int i = 0; i < arg; i++) begin
          for (int k = 0; k < n_pe; k++) begin
            next_cycle();
            wbuf_wren <= n_pe'(1) << k;
            config_data <= random_word();
          end
        end
        next_cycle();
        offset_buf_wren <= 1'b1;
        config_data <= random_word();
      end
      ph_load: begin
        if (arg < n_pe) begin
          load_pe(arg);
        end else begin
          for (int k = 0; k < n_pe; k++) begin
            load_pe(k);
          end
        end
      end
      ph_fifo_wr: begin
        next_cycle();
        acc_fifo_write_en <= 1'b1;  // chain is idle so the tail holds still
      end
      ph_fifo_rd: begin
        next_cycle();
        state_compute <= 1'b1;
        acc_fifo_read_en <= 1'b1;
        repeat (arg - 1) begin
          next_cycle();
          state_compute <= 1'b1;
        end
      end
      default: begin
        repeat (arg) begin
          next_cycle();
          state_compute <= (code == ph_compute);
          if (code == ph_compute) begin
            wbuf_wren <= '1;  // stray writes that every buffer must ignore during compute
            offset_buf_wren <= 1'b1;
          end
        end
      end
    endcase
  endtask

  always @(posedge CLK) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count > cycle_limit) begin
      $display("timeout after %0d cycles, the phase table never finished", cycle_count);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  initial begin
    reset = 1'b1;
    state_compute = 1'b0;
    config_data = '0;
    wbuf_wren = '0;
    offset_buf_wren = 1'b0;
    pe_select_in = '0;
    pe_write_en = 1'b0;
    input_data = '0;
    acc_fifo_write_en = 1'b0;
    acc_fifo_read_en = 1'b0;
    out_sel = '0;
    lfsr_state = 32'h410d;
    cycle_limit = 3 + 3 + margin;  // reset and drain cycles
    for (int p = 0; p < n_phases; p++) begin
      cycle_limit += phase_cycles(phase_code[p], phase_arg[p]);
    end
    repeat (3) @(posedge CLK);
    reset <= 1'b0;
    for (int p = 0; p < n_phases; p++) begin
      run_phase(phase_code[p], phase_arg[p]);
    end
    next_cycle();
    repeat (2) @(posedge CLK);  // let the last values reach the compare
    $display("errors: %0d wrong values, %0d other failures, over %0d checks",
             u_checker.value_errors, u_checker.other_errors, u_checker.check_count);
    if (u_checker.value_errors == 0 && u_checker.other_errors == 0 &&
        u_checker.check_count > 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

//--- dv/npu_compute_checker.sv
module npu_compute_checker #(
  parameter int n_pe = 8,  // chain length of the DUT being watched
  parameter int wbuf_depth = 64,
  parameter int obuf_depth = 16
) (
  input logic CLK,
  input logic reset,
  input logic state_compute,
  input npu_pkg::data_t config_data,
  input logic [n_pe-1:0] wbuf_wren,
  input logic offset_buf_wren,
  input logic [npu_pkg::pe_idx_w-1:0] pe_select_in,
  input logic pe_write_en,
  input npu_pkg::data_t input_data,
  input logic acc_fifo_write_en,
  input logic acc_fifo_read_en,
  input logic [npu_pkg::pe_idx_w-1:0] out_sel,
  input npu_pkg::acc_t pe_dout
);

  npu_pkg::data_t wbuf [n_pe][wbuf_depth];  // expected weight lists, one per PE
  int wcount [n_pe];  // weights written to each PE
  int wptr [n_pe];  // replay position of each weight list
  npu_pkg::data_t obuf [obuf_depth];  // expected offset list
  int ocount;
  int optr;
  npu_pkg::data_t data_m [n_pe];  // expected input data registers
  npu_pkg::acc_t acc_m [n_pe];  // expected accumulators
  npu_pkg::acc_t fifo_q [$];  // expected partial sums, oldest first

  int value_errors = 0;  // wrong pe_dout values
  int other_errors = 0;  // stimulus that broke the scheduler's rules
  int check_count = 0;

  //////////////////////////////
  // reference model, one step per clock
  //////////////////////////////

  always @(posedge CLK) begin : model_step
    npu_pkg::acc_t head;
    npu_pkg::acc_t tail;
    npu_pkg::acc_t carry;
    npu_pkg::data_t w;
    npu_pkg::data_t off;
    if (reset) begin
      for (int k = 0; k < n_pe; k++) begin
        wcount[k] = 0;
        wptr[k] = 0;
        data_m[k] = '0;
        acc_m[k] = '0;
      end
      ocount = 0;
      optr = 0;
      fifo_q.delete();
    end else begin
      tail = acc_m[n_pe-1];  // the push takes the tail as it was before this clock
      off = (ocount == 0) ? npu_pkg::data_t'(0) : obuf[optr];
      head = npu_pkg::acc_t'(off) * (npu_pkg::acc_t'(1) <<< npu_pkg::frac_bits);
      if (acc_fifo_read_en) begin
        if (fifo_q.size() == 0) begin
          other_errors++;  // the scheduler must never pop an empty FIFO
          $display("%0t: stimulus popped the accumulator FIFO while it was empty", $time);
        end else begin
          head = fifo_q.pop_front();  // an earlier partial sum replaces the offset
        end
      end
      if (state_compute) begin
        for (int k = n_pe - 1; k >= 0; k--) begin  // walk from the tail so neighbours are old
          w = (wcount[k] == 0) ? npu_pkg::data_t'(0) : wbuf[k][wptr[k]];
          if (k == 0) begin
            carry = head;
          end else begin
            carry = acc_m[k-1];
          end
          acc_m[k] = carry + npu_pkg::acc_t'(data_m[k]) * npu_pkg::acc_t'(w);
        end
        for (int k = 0; k < n_pe; k++) begin
          if (wcount[k] > 0) begin
            wptr[k] = (wptr[k] == wcount[k] - 1) ? 0 : wptr[k] + 1;  // replay wraps at the count
          end
        end
        if (!acc_fifo_read_en && ocount > 0) begin
          optr = (optr == ocount - 1) ? 0 : optr + 1;
        end
      end else begin
        for (int k = 0; k < n_pe; k++) begin
          if (wbuf_wren[k] && wcount[k] < wbuf_depth) begin
            wbuf[k][wcount[k]] = config_data;  // appended behind the last weight
            wcount[k]++;
          end
        end
        if (offset_buf_wren && ocount < obuf_depth) begin
          obuf[ocount] = config_data;
          ocount++;
        end
      end
      if (acc_fifo_write_en) begin
        fifo_q.push_back(tail);
      end
      for (int k = 0; k < n_pe; k++) begin
        if (pe_write_en && pe_select_in == k) begin
          data_m[k] = input_data;  // only the selected PE takes the word
        end
      end
    end
  end

  //////////////////////////////
  // output compare, mid cycle
  //////////////////////////////

  always @(negedge CLK) begin : compare_output
    npu_pkg::acc_t expected;
    if (!reset) begin
      expected = acc_m[out_sel];  // select is combinational so no delay is expected
      check_count++;
      if (pe_dout !== expected) begin
        value_errors++;
        $display("FAIL %0t pe_dout (out_sel %0d) expected %0d got %0d",
                 $time, out_sel, expected, pe_dout);
      end
    end
  end

endmodule

//--- src/npu_compute_unit.sv
module npu_compute_unit #(
  parameter int n_pe = 8,  // length of the PE chain
  parameter int wbuf_depth = 64,  // weights each PE can replay
  parameter int obuf_depth = 16,  // offsets, one per neuron
  parameter int fifo_depth = 16  // partial sums waiting for the next pass
) (
  input logic CLK,
  input logic reset,
  input logic state_compute,  // high while the chain is computing
  input npu_pkg::data_t config_data,  // broadcast to every buffer
  input logic [n_pe-1:0] wbuf_wren,  // one strobe per weight buffer
  input logic offset_buf_wren,
  input logic [npu_pkg::pe_idx_w-1:0] pe_select_in,  // PE that takes input_data
  input logic pe_write_en,
  input npu_pkg::data_t input_data,
  input logic acc_fifo_write_en,  // push the tail sum
  input logic acc_fifo_read_en,  // head takes the FIFO front instead of the offset
  input logic [npu_pkg::pe_idx_w-1:0] out_sel,  // PE accumulator shown on pe_dout
  output npu_pkg::acc_t pe_dout
);

  npu_pkg::weight_t pe_weight [n_pe];  // current weight of each PE
  npu_pkg::acc_t pe_acc [n_pe];  // accumulator register of each PE
  npu_pkg::acc_t pe_cin [n_pe];  // carry-in of each PE
  logic [n_pe-1:0] pe_load;  // one-hot input load strobes

  npu_pkg::offset_t offset_dout;  // offset for the neuron now entering the chain
  npu_pkg::acc_t offset_wide;  // offset placed above the fraction bits
  npu_pkg::acc_t fifo_dout;  // partial sum from an earlier pass
  npu_pkg::acc_t head_cin;  // value that enters PE 0

  logic offset_rd;
  logic offset_wr;

  //////////////////////////////
  // chain head
  //////////////////////////////

  assign offset_wr = offset_buf_wren && !state_compute;  // configuration only outside compute
  assign offset_rd = state_compute && !acc_fifo_read_en;  // no step while a FIFO sum is used

  npu_circ_buf #(
    .payload_t(npu_pkg::offset_t),
    .depth(obuf_depth)
  ) u_offset_buf (
    .CLK(CLK),
    .reset(reset),
    .read_en(offset_rd),
    .write_en(offset_wr),
    .din(config_data),
    .dout(offset_dout)
  );

  // sign-extend first so the shift keeps the sign of the offset
  assign offset_wide = npu_pkg::acc_t'(offset_dout) <<< npu_pkg::frac_bits;
  assign head_cin = acc_fifo_read_en ? fifo_dout : offset_wide;  // multi-pass sums resume here

  //////////////////////////////
  // PE chain
  //////////////////////////////

  for (genvar k = 0; k < n_pe; k++) begin : g_pe
    logic wbuf_wr;  // this PE's weight write, held off during compute

    assign wbuf_wr = wbuf_wren[k] && !state_compute;
    assign pe_load[k] = pe_write_en && (pe_select_in == npu_pkg::pe_idx_w'(k));  // one-hot

    if (k == 0) begin : g_head
      assign pe_cin[k] = head_cin;  // PE 0 starts from the offset or the FIFO
    end else begin : g_link
      assign pe_cin[k] = pe_acc[k-1];  // every other PE adds onto its neighbour
    end

    npu_circ_buf #(
      .payload_t(npu_pkg::weight_t),
      .depth(wbuf_depth)
    ) u_wbuf (
      .CLK(CLK),
      .reset(reset),
      .read_en(state_compute),  // one weight per compute clock
      .write_en(wbuf_wr),
      .din(config_data),
      .dout(pe_weight[k])  // each PE reads its own buffer
    );

    npu_proc_eng u_pe (
      .CLK(CLK),
      .reset(reset),
      .new_input_wren(pe_load[k]),
      .pe_en(state_compute),
      .data_in(input_data),  // input always comes from the port
      .weight_in(pe_weight[k]),
      .acc_in(pe_cin[k]),
      .acc_out(pe_acc[k])
    );
  end

  //////////////////////////////
  // tail FIFO and output select
  //////////////////////////////

  npu_accum_fifo #(
    .depth(fifo_depth)
  ) u_accum_fifo (
    .CLK(CLK),
    .reset(reset),
    .wr_en(acc_fifo_write_en),
    .rd_en(acc_fifo_read_en),
    .din(pe_acc[n_pe-1]),  // the last PE holds the finished partial sum
    .dout(fifo_dout)
  );

  always_comb begin
    pe_dout = '0;  // an index past the last PE reads zero
    for (int k = 0; k < n_pe; k++) begin
      if (out_sel == npu_pkg::pe_idx_w'(k)) begin
        pe_dout = pe_acc[k];  // no register so the sweep sees each PE without delay
      end
    end
  end

endmodule

//--- src/npu_accum_fifo.sv
module npu_accum_fifo #(
  parameter int depth = 16  // partial sums that can wait between passes
) (
  input logic CLK,
  input logic reset,
  input logic wr_en,  // pushes the tail accumulator
  input logic rd_en,  // pops the front word after the head has used it
  input npu_pkg::acc_t din,
  output npu_pkg::acc_t dout
);

  localparam int addr_w = (depth > 1) ? $clog2(depth) : 1;  // pointer width into the array

  npu_pkg::acc_t mem [depth];  // tail sums in push order

  logic [addr_w-1:0] wr_ptr;  // next free slot
  logic [addr_w-1:0] rd_ptr;  // oldest stored sum
  logic [addr_w-1:0] wr_ptr_next;
  logic [addr_w-1:0] rd_ptr_next;

  // depth need not be a power of two so both pointers wrap by compare
  assign wr_ptr_next = (wr_ptr == addr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
  assign rd_ptr_next = (rd_ptr == addr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;

  //////////////////////////////
  // storage
  //////////////////////////////

  always_ff @(posedge CLK) begin
    if (wr_en) begin
      mem[wr_ptr] <= din;  // the scheduler never pushes into a full FIFO
    end
  end

  //////////////////////////////
  // pointers
  //////////////////////////////

  always_ff @(posedge CLK) begin
    if (reset) begin
      wr_ptr <= '0;  // empty after reset
      rd_ptr <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr_next;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr_next;  // the scheduler never pops an empty FIFO
      end
    end
  end

  assign dout = mem[rd_ptr];  // front word shows one clock after its push

endmodule

//--- src/npu_proc_eng.sv
module npu_proc_eng (
  input logic CLK,
  input logic reset,
  input logic new_input_wren,  // one-hot load strobe from the write decode
  input logic pe_en,  // high on every compute clock
  input npu_pkg::data_t data_in,  // broadcast input word
  input npu_pkg::weight_t weight_in,  // current entry of this PE's weight buffer
  input npu_pkg::acc_t acc_in,  // carry-in from the previous PE or the chain head
  output npu_pkg::acc_t acc_out
);

  localparam int prod_w = 2 * npu_pkg::data_w;  // full width of a signed 16x16 product

  npu_pkg::data_t data_reg;  // input word held for a whole neuron pass
  logic signed [prod_w-1:0] product;  // data times weight before widening
  npu_pkg::acc_t product_ext;  // product sign-extended to the accumulator

  assign product = data_reg * weight_in;  // both operands signed so the multiply is signed
  assign product_ext = npu_pkg::acc_t'(product);  // a signed size cast copies the sign bit up

  //////////////////////////////
  // input data register
  //////////////////////////////

  always_ff @(posedge CLK) begin
    if (reset) begin
      data_reg <= '0;
    end else if (new_input_wren) begin
      data_reg <= data_in;  // visible to the multiplier on the next clock
    end
  end

  //////////////////////////////
  // multiply-accumulate stage
  //////////////////////////////

  always_ff @(posedge CLK) begin
    if (reset) begin
      acc_out <= '0;  // pe_dout reads zero until the first compute clock
    end else if (pe_en) begin
      acc_out <= acc_in + product_ext;  // the sum moves one PE down the chain per clock
    end
  end

endmodule

//--- src/npu_circ_buf.sv
module npu_circ_buf #(
  parameter type payload_t = npu_pkg::data_t,  // weight_t or offset_t at the top level
  parameter int depth = 16  // number of entries the buffer can hold
) (
  input logic CLK,
  input logic reset,
  input logic read_en,  // steps the replay pointer once per clock
  input logic write_en,  // appends din behind the last written entry
  input payload_t din,
  output payload_t dout
);

  localparam int addr_w = (depth > 1) ? $clog2(depth) : 1;  // index into the storage
  localparam int cnt_w = $clog2(depth + 1);  // the count must be able to reach depth

  payload_t mem [depth];  // configured list, replayed in write order

  logic [addr_w-1:0] rd_ptr;  // entry currently shown on dout
  logic [cnt_w-1:0] wr_cnt;  // number of valid entries, also the next write slot
  logic [cnt_w-1:0] rd_last;  // count minus one marks where the pointer wraps
  logic do_write;  // write that still fits in the storage

  assign do_write = write_en && (wr_cnt < cnt_w'(depth));  // extra writes past depth are lost
  assign rd_last = wr_cnt - 1'b1;

  // only entries below the write count are ever shown on dout
  always_ff @(posedge CLK) begin
    if (do_write) begin
      mem[wr_cnt[addr_w-1:0]] <= din;  // lands at the count and is readable next clock
    end
  end

  always_ff @(posedge CLK) begin
    if (reset) begin
      wr_cnt <= '0;  // an empty buffer waits for a fresh configuration
      rd_ptr <= '0;
    end else begin
      if (do_write) begin
        wr_cnt <= wr_cnt + 1'b1;
      end
      if (read_en && (wr_cnt != '0)) begin
        if (cnt_w'(rd_ptr) == rd_last) begin
          rd_ptr <= '0;  // wrap after the last written entry so the list replays
        end else begin
          rd_ptr <= rd_ptr + 1'b1;
        end
      end
    end
  end

  // zero while nothing has been written so no unknown value enters the chain
  assign dout = (wr_cnt == '0) ? payload_t'('0) : mem[rd_ptr];  // no register on the read side

endmodule

//--- src/npu_pkg.sv
package npu_pkg;

  //////////////////////////////
  // datapath widths
  //////////////////////////////

  localparam int data_w = 16;  // input words, weights and offsets share this width
  localparam int acc_w = 48;  // wide enough for a long chain of 16x16 products

  // offsets sit above this many fraction bits once they join the accumulator
  localparam int frac_bits = 7;

  localparam int pe_idx_w = 3;  // selects one of the PEs on the write and output paths

  //////////////////////////////
  // datapath types
  //////////////////////////////

  typedef logic signed [data_w-1:0] data_t;  // activation word coming from the input port

  typedef logic signed [data_w-1:0] weight_t;  // one entry of a per-PE weight buffer

  typedef logic signed [data_w-1:0] offset_t;  // bias that seeds the head of the chain

  typedef logic signed [acc_w-1:0] acc_t;  // running sum carried from PE to PE

endpackage
